// File: run.sh
#!/bin/sh
# build the FIR testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module tb_fir_top -f sim.f -o tb_fir_top

status=0
./obj_dir/tb_fir_top > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
	exit 1
fi
exit "$status"

// File: sim.f
+incdir+src
src/axi_pkg.sv
src/fir_pkg.sv
src/axi_lite_ctrl.sv
src/fir_regs.sv
src/fir_seq.sv
src/tap_counter.sv
src/coef_bank.sv
src/fir_mac.sv
src/fir_top.sv
sim/tb_fir_top.sv

// File: sim/tb_fir_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fir_cfg.svh"

module tb_fir_top;

	localparam int     LATENCY    = `FIR_TAPS + 2;   // ack rise to strobe in cycles
	localparam int     EST_CYCLES = 16 + 28 * 14 + 62 * (LATENCY + 4);
	localparam longint LIMIT_NS   = 20 * EST_CYCLES * 8;

	logic                 S_AXI_ACLK;
	logic                 S_AXI_ARESETN;
	axi_pkg::axi_wr_req_t wr_req;
	axi_pkg::axi_wr_rsp_t wr_rsp;
	axi_pkg::axi_rd_req_t rd_req;
	axi_pkg::axi_rd_rsp_t rd_rsp;
	fir_pkg::sample_t     flt_in;
	logic                 in_req;
	logic                 in_ack;
	fir_pkg::sample_t     flt_out;
	logic                 out_strobe;
	logic [7:0]           leds;

	int               err_cnt   = 0;
	int               test_cnt  = 0;
	int               test_fail = 0;
	int               cycle     = 0;   // free running cycle count for latency
	int               ack_rises = 0;
	int               strobes   = 0;
	int               sent      = 0;
	logic             ack_q;
	logic             owed;   // ack seen and its strobe still pending
	logic [31:0]      rng;
	fir_pkg::sample_t model_hist [`FIR_TAPS];   // [0] newest
	fir_pkg::coef_t   model_coef [`FIR_TAPS];

	fir_top dut (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.wr_req        (wr_req),
		.wr_rsp        (wr_rsp),
		.rd_req        (rd_req),
		.rd_rsp        (rd_rsp),
		.flt_in        (flt_in),
		.in_req        (in_req),
		.in_ack        (in_ack),
		.flt_out       (flt_out),
		.out_strobe    (out_strobe),
		.leds          (leds)
	);

	always #4 S_AXI_ACLK = ~S_AXI_ACLK;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	// sum of c[k]*h[k] with products and sums wrapped to 31 bits, top 14 bits out
	function automatic fir_pkg::sample_t model_out();
		logic signed [31:0] p;
		logic signed [30:0] acc;
		int                 k;
		acc = '0;
		for (k = 0; k < `FIR_TAPS; k++) begin
			p   = model_coef[k] * model_hist[k];
			acc = acc + p[30:0];
		end
		return acc[30:17];
	endfunction

	function void rule_broken(input string msg);
		err_cnt++;
		$display("handshake rule broken at %0t: %s", $time, msg);
	endfunction

	task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			err_cnt++;
			$display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic test_done(input int num, input string name, input int errs_before);
		test_cnt++;
		if (err_cnt == errs_before) begin
			$display("test %0d %s: ok", num, name);
		end else begin
			test_fail++;
			$display("test %0d %s: failed with %0d errors", num, name, err_cnt - errs_before);
		end
	endtask

	task automatic axi_write(input logic [15:0] addr, input logic [31:0] data, input int b_wait);
		@(posedge S_AXI_ACLK);
		#1;
		wr_req.awaddr  = addr;
		wr_req.wdata   = data;
		wr_req.awvalid = 1'b1;
		wr_req.wvalid  = 1'b1;
		@(negedge S_AXI_ACLK);
		while (!wr_rsp.awready) @(negedge S_AXI_ACLK);
		@(posedge S_AXI_ACLK);   // handshake edge
		#1;
		wr_req.awvalid = 1'b0;
		wr_req.wvalid  = 1'b0;
		repeat (b_wait) begin
			@(posedge S_AXI_ACLK);   // response held back
			#1;
		end
		wr_req.bready = 1'b1;
		@(negedge S_AXI_ACLK);
		while (!wr_rsp.bvalid) @(negedge S_AXI_ACLK);
		@(posedge S_AXI_ACLK);
		#1;
		wr_req.bready = 1'b0;
	endtask

	// second write offered right behind the first while its response is held back
	task automatic write_while_held(input logic [15:0] addr, input logic [31:0] d0,
		input logic [31:0] d1, input int b_wait);
		@(posedge S_AXI_ACLK);
		#1;
		wr_req.awaddr  = addr;
		wr_req.wdata   = d0;
		wr_req.awvalid = 1'b1;
		wr_req.wvalid  = 1'b1;
		@(negedge S_AXI_ACLK);
		while (!wr_rsp.awready) @(negedge S_AXI_ACLK);
		@(posedge S_AXI_ACLK);   // handshake edge
		#1;
		wr_req.wdata = d1;   // valids stay up for the second write
		repeat (b_wait) begin
			@(posedge S_AXI_ACLK);
			#1;
		end
		wr_req.bready = 1'b1;
		@(negedge S_AXI_ACLK);
		while (!wr_rsp.bvalid) @(negedge S_AXI_ACLK);
		@(posedge S_AXI_ACLK);
		#1;
		wr_req.bready = 1'b0;
		axi_write(addr, d1, 0);
	endtask

	task automatic axi_read(input logic [15:0] addr, input int r_wait, output logic [31:0] data);
		@(posedge S_AXI_ACLK);
		#1;
		rd_req.araddr  = addr;
		rd_req.arvalid = 1'b1;
		@(negedge S_AXI_ACLK);
		while (!rd_rsp.arready) @(negedge S_AXI_ACLK);
		@(posedge S_AXI_ACLK);
		#1;
		rd_req.arvalid = 1'b0;
		repeat (r_wait) begin
			@(posedge S_AXI_ACLK);
			#1;
		end
		rd_req.rready = 1'b1;
		@(negedge S_AXI_ACLK);
		while (!rd_rsp.rvalid) @(negedge S_AXI_ACLK);
		data = rd_rsp.rdata;
		expect_eq("rresp", 32'(rd_rsp.rresp), 32'h0);   // OKAY
		@(posedge S_AXI_ACLK);
		#1;
		rd_req.rready = 1'b0;
	endtask

	// second read offered right behind the first while its data is held back
	task automatic read_while_held(input logic [15:0] a0, input logic [15:0] a1,
		input int r_wait, output logic [31:0] d0, output logic [31:0] d1);
		@(posedge S_AXI_ACLK);
		#1;
		rd_req.araddr  = a0;
		rd_req.arvalid = 1'b1;
		@(negedge S_AXI_ACLK);
		while (!rd_rsp.arready) @(negedge S_AXI_ACLK);
		@(posedge S_AXI_ACLK);
		#1;
		rd_req.araddr = a1;   // arvalid stays up for the second read
		repeat (r_wait) begin
			@(posedge S_AXI_ACLK);
			#1;
		end
		rd_req.rready = 1'b1;
		@(negedge S_AXI_ACLK);
		while (!rd_rsp.rvalid) @(negedge S_AXI_ACLK);
		d0 = rd_rsp.rdata;
		expect_eq("rresp", 32'(rd_rsp.rresp), 32'h0);
		@(posedge S_AXI_ACLK);
		#1;
		rd_req.rready = 1'b0;
		axi_read(a1, 0, d1);
	endtask

	// four phase req/ack followed by the wait for the result strobe
	// with early set the next request goes up before this strobe
	task automatic send_sample(input fir_pkg::sample_t s, output fir_pkg::sample_t y,
		input logic early = 1'b0, input fir_pkg::sample_t next_s = '0);
		int t_ack;
		int k;
		@(posedge S_AXI_ACLK);
		#1;
		flt_in = s;
		in_req = 1'b1;
		@(negedge S_AXI_ACLK);
		while (!in_ack) @(negedge S_AXI_ACLK);
		t_ack = cycle;
		@(posedge S_AXI_ACLK);
		#1;
		in_req = 1'b0;
		@(negedge S_AXI_ACLK);
		while (in_ack) @(negedge S_AXI_ACLK);
		if (early) begin
			@(posedge S_AXI_ACLK);
			#1;
			flt_in = next_s;
			in_req = 1'b1;
		end
		while (!out_strobe) @(negedge S_AXI_ACLK);
		y = flt_out;
		expect_eq("strobe latency", 32'(cycle - t_ack), 32'(LATENCY));
		for (k = `FIR_TAPS - 1; k > 0; k--) begin
			model_hist[k] = model_hist[k-1];
		end
		model_hist[0] = s;   // history shifts in bypass too
		sent++;
	endtask

	always @(posedge S_AXI_ACLK) begin
		cycle <= cycle + 1;
		if (!S_AXI_ARESETN) begin
			ack_q <= 1'b0;
			owed  <= 1'b0;
		end else begin
			ack_q <= in_ack;
			if (in_ack && !ack_q) begin
				owed      <= 1'b1;
				ack_rises <= ack_rises + 1;
			end else if (out_strobe) begin
				owed <= 1'b0;
			end
			if (out_strobe) begin
				strobes <= strobes + 1;
			end
		end
	end

	a_aw_w: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		wr_rsp.awready == wr_rsp.wready) else rule_broken("awready and wready differ");
	a_aw_b: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		wr_rsp.awready |=> (!wr_rsp.awready && wr_rsp.bvalid))
		else rule_broken("awready longer than one cycle or no bvalid after it");
	a_b_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(wr_rsp.bvalid && !wr_req.bready) |=> (wr_rsp.bvalid && !wr_rsp.awready))
		else rule_broken("bvalid dropped or a write taken while the response waits");
	a_b_okay: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		wr_rsp.bvalid |-> (wr_rsp.bresp == 2'b00)) else rule_broken("bresp is not OKAY");
	a_ar_r: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		rd_rsp.arready |=> (!rd_rsp.arready && rd_rsp.rvalid))
		else rule_broken("arready longer than one cycle or no rvalid after it");
	a_r_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(rd_rsp.rvalid && !rd_req.rready) |=>
		(rd_rsp.rvalid && !rd_rsp.arready && $stable(rd_rsp.rdata)))
		else rule_broken("rvalid or rdata changed while the read data waits");
	a_strobe: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		out_strobe |=> !out_strobe) else rule_broken("out_strobe longer than one cycle");
	a_ack_pair: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(in_ack && !ack_q) |-> !owed) else rule_broken("new ack before the previous strobe");
	a_strobe_owed: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		out_strobe |-> owed) else rule_broken("out_strobe without a pending ack");
	a_ack_release: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		$fell(in_ack) |-> !$past(in_req)) else rule_broken("in_ack fell while in_req was high");

	initial begin
		fir_pkg::sample_t s;
		fir_pkg::sample_t y;
		fir_pkg::sample_t neg;
		fir_pkg::sample_t nxt;
		logic [31:0]      w;
		logic [31:0]      w2;
		int               e0;
		int               i;
		S_AXI_ACLK    = 1'b0;
		S_AXI_ARESETN = 1'b0;
		wr_req        = '0;
		rd_req        = '0;
		flt_in        = '0;
		in_req        = 1'b0;
		rng           = 32'h81cca5fc;
		for (i = 0; i < `FIR_TAPS; i++) begin
			model_hist[i] = '0;
			model_coef[i] = '0;
		end
		repeat (16) @(posedge S_AXI_ACLK);
		#1;
		S_AXI_ARESETN = 1'b1;

		e0 = err_cnt;
		@(negedge S_AXI_ACLK);
		expect_eq("handshake outputs after reset", {wr_rsp.awready, wr_rsp.wready,
			wr_rsp.bvalid, rd_rsp.arready, rd_rsp.rvalid, in_ack, out_strobe}, 32'h0);
		expect_eq("leds after reset", leds, 32'h0);
		axi_read(16'h0000, 0, w);
		expect_eq("name word", w, 32'h2052_4946);   // " RIF"
		axi_read(16'h0004, 0, w);
		expect_eq("version word", w, 32'h3032_2e33);   // "02.3"
		axi_read(16'h0010, 0, w);
		expect_eq("tap count", w, 32'd8);
		axi_read(16'h0030, 0, w);
		expect_eq("coef fraction bits", w, 32'd17);
		axi_read(16'h0008, 0, w);
		expect_eq("unmapped word", w, 32'h0);
		test_done(1, "reset and id words", e0);

		e0 = err_cnt;
		axi_write(16'h0050, 32'hdead_bea5, 5);   // enable bit clear
		axi_read(16'h0050, 6, w);
		expect_eq("switch readback", w, 32'hdead_bea5);
		expect_eq("leds", leds, 32'ha5);
		axi_write(16'h0050, 32'h0000_005c, 0);
		axi_read(16'h0050, 0, w);
		expect_eq("switch readback", w, 32'h0000_005c);
		expect_eq("leds", leds, 32'h5c);
		write_while_held(16'h0050, 32'h1234_5631, 32'h0000_00c4, 3);
		read_while_held(16'h0050, 16'h0004, 3, w, w2);
		expect_eq("switch readback", w, 32'h0000_00c4);
		expect_eq("leds", leds, 32'hc4);
		expect_eq("version word", w2, 32'h3032_2e33);
		axi_write(16'h0050, 32'h0, 2);
		test_done(2, "register writes and held responses", e0);

		e0 = err_cnt;
		for (i = 0; i < 6; i++) begin
			rng = xorshift(rng);
			s   = fir_pkg::sample_t'(rng[13:0]);
			send_sample(s, y);
			expect_eq("bypass output", y, s);
		end
		test_done(3, "bypass", e0);

		// full scale coefficient is the sign bit alone and gives a gain of -1
		e0 = err_cnt;
		axi_write(16'h0050, 32'h0000_0002, 0);
		axi_write(16'h0100, 32'h8000_0000, 0);
		for (i = 0; i < 4; i++) begin
			rng = xorshift(rng);
			s   = fir_pkg::sample_t'(rng[13:0]);
			send_sample(s, y);
			neg = -s;
			expect_eq("tap 0 unit gain", y, neg);
		end
		axi_write(16'h0100, 32'h0, 0);
		axi_write(16'h010c, 32'h8000_0000, 0);
		for (i = 0; i < 6; i++) begin
			rng = xorshift(rng);
			s   = fir_pkg::sample_t'(rng[13:0]);
			send_sample(s, y);
			neg = -model_hist[3];   // three samples back
			expect_eq("tap 3 unit gain", y, neg);
		end
		test_done(4, "unit coefficients", e0);

		e0 = err_cnt;
		for (i = 0; i < `FIR_TAPS; i++) begin
			rng   = xorshift(rng);
			w     = rng;
			w[31] = i[0];   // odd taps negative with random middle bits that are ignored
			axi_write(16'h0100 + 16'(4 * i), w, i % 3);
			model_coef[i] = {w[31], w[16:0]};
		end
		for (i = 0; i < 40; i++) begin
			rng = xorshift(rng);
			s   = fir_pkg::sample_t'(rng[13:0]);
			send_sample(s, y);
			expect_eq("filter output", y, model_out());
		end
		test_done(5, "random coefficients", e0);

		// requests raised before the previous strobe must wait for it
		e0 = err_cnt;
		rng = xorshift(rng);
		s   = fir_pkg::sample_t'(rng[13:0]);
		for (i = 0; i < 6; i++) begin
			rng = xorshift(rng);
			nxt = fir_pkg::sample_t'(rng[13:0]);
			send_sample(s, y, i < 5, nxt);
			expect_eq("filter output after early request", y, model_out());
			s = nxt;
		end
		repeat (2) @(posedge S_AXI_ACLK);   // let the last strobe be counted
		#1;
		expect_eq("acks against strobes", ack_rises, strobes);
		expect_eq("strobes against samples", strobes, sent);
		test_done(6, "ack and strobe pairing", e0);

		$display("%0d tests, %0d failed, %0d errors", test_cnt, test_fail, err_cnt);
		if (err_cnt == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	initial begin
		#(LIMIT_NS);
		$display("timeout: tests did not finish within %0d ns", LIMIT_NS);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: src/axi_lite_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_ctrl (
	input  wire                       S_AXI_ACLK,
	input  wire                       S_AXI_ARESETN,
	input  wire axi_pkg::axi_wr_req_t wr_req,
	output axi_pkg::axi_wr_rsp_t      wr_rsp,
	input  wire axi_pkg::axi_rd_req_t rd_req,
	output axi_pkg::axi_rd_rsp_t      rd_rsp,
	output fir_pkg::reg_wr_t          reg_wr,
	output fir_pkg::word_addr_t       rd_addr,
	input  wire [31:0]                rd_data
);

	localparam logic [1:0] W_IDLE = 2'd0;
	localparam logic [1:0] W_ACK  = 2'd1;   // awready and wready high
	localparam logic [1:0] W_RESP = 2'd2;   // bvalid held until bready
	localparam logic [1:0] R_IDLE = 2'd0;
	localparam logic [1:0] R_ACK  = 2'd1;
	localparam logic [1:0] R_DATA = 2'd2;

	logic [1:0]          wr_state;
	logic [1:0]          rd_state;
	fir_pkg::word_addr_t wr_addr;   // taken when address and data both arrive
	logic [31:0]         rdata_q;

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			wr_state <= W_IDLE;
			rd_state <= R_IDLE;
		end else begin
			case (wr_state)
				W_IDLE: if (wr_req.awvalid && wr_req.wvalid) begin
					wr_state <= W_ACK;
				end
				W_ACK: wr_state <= W_RESP;
				W_RESP: if (wr_req.bready) begin
					wr_state <= W_IDLE;   // next write only after the response is taken
				end
				default: wr_state <= W_IDLE;
			endcase
			case (rd_state)
				R_IDLE: if (rd_req.arvalid) begin
					rd_state <= R_ACK;
				end
				R_ACK: rd_state <= R_DATA;
				R_DATA: if (rd_req.rready) begin
					rd_state <= R_IDLE;
				end
				default: rd_state <= R_IDLE;
			endcase
		end
	end

	// addresses and read data
	always_ff @(posedge S_AXI_ACLK) begin
		if (wr_state == W_IDLE) begin
			wr_addr <= fir_pkg::word_addr_t'(wr_req.awaddr >> 2);
		end
		if (rd_state == R_IDLE) begin
			rd_addr <= fir_pkg::word_addr_t'(rd_req.araddr >> 2);
		end
		if (rd_state == R_ACK) begin
			rdata_q <= rd_data;   // value at the handshake, kept while rvalid waits
		end
	end

	always_comb begin
		wr_rsp.awready = (wr_state == W_ACK);
		wr_rsp.wready  = (wr_state == W_ACK);
		wr_rsp.bresp   = 2'b00;
		wr_rsp.bvalid  = (wr_state == W_RESP);
		rd_rsp.arready = (rd_state == R_ACK);
		rd_rsp.rdata   = rdata_q;
		rd_rsp.rresp   = 2'b00;
		rd_rsp.rvalid  = (rd_state == R_DATA);
		// write event on the handshake cycle, register updates on the next edge
		reg_wr.valid = (wr_state == W_ACK) && wr_req.awvalid && wr_req.wvalid;
		reg_wr.addr  = wr_addr;
		reg_wr.data  = wr_req.wdata;
	end

endmodule

`default_nettype wire

// File: src/axi_pkg.sv
`default_nettype none

`include "fir_cfg.svh"

package axi_pkg;

	// single beat write, address and data presented together
	typedef struct packed {
		logic [`FIR_AXI_ADDR_W-1:0] awaddr;
		logic                       awvalid;
		logic [31:0]                wdata;
		logic                       wvalid;
		logic                       bready;
	} axi_wr_req_t;

	typedef struct packed {
		logic       awready;
		logic       wready;
		logic [1:0] bresp;   // only OKAY is ever returned
		logic       bvalid;
	} axi_wr_rsp_t;

	typedef struct packed {
		logic [`FIR_AXI_ADDR_W-1:0] araddr;
		logic                       arvalid;
		logic                       rready;
	} axi_rd_req_t;

	typedef struct packed {
		logic        arready;
		logic [31:0] rdata;
		logic [1:0]  rresp;
		logic        rvalid;
	} axi_rd_rsp_t;

endpackage

`default_nettype wire

// File: src/coef_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "fir_cfg.svh"

module coef_bank (
	input  wire                    S_AXI_ACLK,
	input  wire                    S_AXI_ARESETN,
	input  wire fir_pkg::coef_wr_t coef_wr,
	input  wire fir_pkg::tap_idx_t rd_tap,
	output fir_pkg::coef_t         coef
);

	fir_pkg::coef_t mem [`FIR_TAPS];   // small, kept in flops

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			for (int i = 0; i < `FIR_TAPS; i++) begin
				mem[i] <= '0;   // all taps zero until programmed
			end
		end else if (coef_wr.valid) begin
			mem[coef_wr.tap] <= coef_wr.coef;
		end
	end

	// one cycle read latency, fir_mac delays its tap index to match
	always_ff @(posedge S_AXI_ACLK) begin
		coef <= mem[rd_tap];
	end

endmodule

`default_nettype wire

// File: src/fir_cfg.svh
`ifndef FIR_CFG_SVH
`define FIR_CFG_SVH

// filter geometry
`define FIR_TAPS        8
`define FIR_DATA_W      14  // sample width, in and out
`define FIR_COEF_W      18  // sign plus magnitude
`define FIR_COEF_MAG    17  // fractional bits, 2^17 is unity gain

`define FIR_AXI_ADDR_W  16  // byte address on the bus

// register map in 32 bit words
`define FIR_REG_NAME    0
`define FIR_REG_VER     1
`define FIR_REG_TAPS    4
`define FIR_REG_MAG     12
`define FIR_REG_SWITCH  20
`define FIR_COEF_BASE   64  // write window, tap k at base + k

`define FIR_SW_EN       1   // filter enable bit of the switch word

// id words come out byte reversed when read as text
`define FIR_ID_NAME     " RIF"
`define FIR_ID_VER      "02.3"

`endif

// File: src/fir_mac.sv
`timescale 1ns/1ps
`default_nettype none

`include "fir_cfg.svh"

module fir_mac (
	input  wire                    S_AXI_ACLK,
	input  wire                    S_AXI_ARESETN,
	input  wire fir_pkg::sample_t  flt_in,
	input  wire                    load,
	input  wire fir_pkg::tap_idx_t tap,
	input  wire fir_pkg::coef_t    coef,
	input  wire                    finish,
	input  wire                    fir_en,
	output fir_pkg::sample_t       flt_out,
	output logic                   out_strobe
);

	fir_pkg::sample_t                          hist [`FIR_TAPS];   // hist[0] newest
	fir_pkg::tap_idx_t                         tap_d;   // lines up with coef
	logic signed [`FIR_COEF_W+`FIR_DATA_W-1:0] mult;
	fir_pkg::acc_t                             prod;
	fir_pkg::acc_t                             acc;
	fir_pkg::acc_t                             acc_base;
	fir_pkg::acc_t                             acc_sum;
	logic [2:0]                                load_d;   // bit 2 flags the tap 0 product

	assign mult     = coef * hist[tap_d];
	assign acc_base = load_d[2] ? '0 : acc;   // start each sample from zero
	assign acc_sum  = acc_base + prod;

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			for (int k = 0; k < `FIR_TAPS; k++) begin
				hist[k] <= '0;
			end
		end else if (load) begin
			hist[0] <= flt_in;
			for (int k = 1; k < `FIR_TAPS; k++) begin
				hist[k] <= hist[k-1];
			end
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			load_d     <= '0;
			out_strobe <= 1'b0;
		end else begin
			load_d     <= {load_d[1:0], load};
			out_strobe <= finish;
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		tap_d <= tap;
		prod  <= fir_pkg::acc_t'(mult);   // product wraps to accumulator width
		acc   <= acc_sum;
		if (finish) begin
			// last product is folded in here, so no extra cycle for the final sum
			flt_out <= fir_en ? acc_sum[`FIR_DATA_W+`FIR_COEF_MAG-1:`FIR_COEF_MAG] : hist[0];
		end
	end

endmodule

`default_nettype wire

// File: src/fir_pkg.sv
`default_nettype none

`include "fir_cfg.svh"

package fir_pkg;

	typedef logic signed [`FIR_DATA_W-1:0] sample_t;
	typedef logic signed [`FIR_COEF_W-1:0] coef_t;
	typedef logic signed [`FIR_DATA_W+`FIR_COEF_MAG-1:0] acc_t;   // wraps, no saturation
	typedef logic [$clog2(`FIR_TAPS)-1:0] tap_idx_t;
	typedef logic [`FIR_AXI_ADDR_W-3:0] word_addr_t;   // byte offset removed

	// one register write, valid for a single cycle
	typedef struct packed {
		logic        valid;
		word_addr_t  addr;
		logic [31:0] data;
	} reg_wr_t;

	typedef struct packed {
		logic     valid;
		tap_idx_t tap;
		coef_t    coef;
	} coef_wr_t;

	// bus word, either taken whole or split into a sign/magnitude coefficient
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic                      sign;   // bit 31
			logic [30-`FIR_COEF_MAG:0] ign;    // not stored
			logic [`FIR_COEF_MAG-1:0]  mag;
		} coef;
	} coef_word_u;

endpackage

`default_nettype wire

// File: src/fir_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "fir_cfg.svh"

module fir_regs (
	input  wire                      S_AXI_ACLK,
	input  wire                      S_AXI_ARESETN,
	input  wire fir_pkg::reg_wr_t    reg_wr,
	input  wire fir_pkg::word_addr_t rd_addr,
	output logic [31:0]              rd_data,
	output fir_pkg::coef_wr_t        coef_wr,
	output logic                     fir_en,
	output logic [7:0]               leds
);

	fir_pkg::coef_word_u wr_word;
	fir_pkg::word_addr_t coef_off;   // offset into the coefficient window
	logic                sw_wr;
	logic [31:0]         switches;

	assign wr_word  = reg_wr.data;
	assign coef_off = reg_wr.addr - fir_pkg::word_addr_t'(`FIR_COEF_BASE);
	assign sw_wr    = reg_wr.valid && (reg_wr.addr == fir_pkg::word_addr_t'(`FIR_REG_SWITCH));

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			switches <= '0;   // filter off, leds dark
		end else if (sw_wr) begin
			switches <= wr_word.raw;
		end
	end

	assign leds   = switches[7:0];
	assign fir_en = switches[`FIR_SW_EN];

	// below the base the offset wraps high and falls out of the window
	always_comb begin
		coef_wr.valid = reg_wr.valid && (coef_off < fir_pkg::word_addr_t'(`FIR_TAPS));
		coef_wr.tap   = fir_pkg::tap_idx_t'(coef_off);
		coef_wr.coef  = {wr_word.coef.sign, wr_word.coef.mag};   // drop the ignored middle bits
	end

	always_comb begin
		case (rd_addr)
			fir_pkg::word_addr_t'(`FIR_REG_NAME):   rd_data = `FIR_ID_NAME;
			fir_pkg::word_addr_t'(`FIR_REG_VER):    rd_data = `FIR_ID_VER;
			fir_pkg::word_addr_t'(`FIR_REG_TAPS):   rd_data = 32'(`FIR_TAPS);
			fir_pkg::word_addr_t'(`FIR_REG_MAG):    rd_data = 32'(`FIR_COEF_MAG);
			fir_pkg::word_addr_t'(`FIR_REG_SWITCH): rd_data = switches;
			default:                                rd_data = '0;   // unmapped, coefs are write only
		endcase
	end

endmodule

`default_nettype wire

// File: src/fir_seq.sv
`timescale 1ns/1ps
`default_nettype none

module fir_seq (
	input  wire  S_AXI_ACLK,
	input  wire  S_AXI_ARESETN,
	input  wire  in_req,
	output logic in_ack,
	input  wire  last,
	output logic start,
	output logic load,
	output logic finish
);

	localparam logic [2:0] S_IDLE  = 3'd0;
	localparam logic [2:0] S_ACK   = 3'd1;
	localparam logic [2:0] S_RUN   = 3'd2;   // taps being read
	localparam logic [2:0] S_DRAIN = 3'd3;   // coef read and product stages
	localparam logic [2:0] S_WAIT  = 3'd4;   // result out, old req still up

	logic [2:0] state;
	logic [1:0] last_d;
	logic       accept;

	assign accept = (state == S_IDLE) && in_req;
	assign load   = accept;   // sample into history, mac restarts
	assign start  = accept;   // tap 0 on the next cycle
	assign finish = (state == S_DRAIN) && last_d[1];

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			state  <= S_IDLE;
			in_ack <= 1'b0;
			last_d <= '0;
		end else begin
			last_d <= {last_d[0], last};
			if (accept) begin
				in_ack <= 1'b1;
			end else if (!in_req) begin
				in_ack <= 1'b0;   // one cycle after req falls
			end
			case (state)
				S_IDLE: if (in_req) begin
					state <= S_ACK;
				end
				S_ACK: state <= S_RUN;
				S_RUN: if (last) begin
					state <= S_DRAIN;
				end
				S_DRAIN: if (last_d[1]) begin
					state <= S_WAIT;
				end
				S_WAIT: if (!in_ack) begin
					state <= S_IDLE;   // a held req is not taken twice
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/fir_top.sv
`timescale 1ns/1ps
`default_nettype none

module fir_top (
	input  wire                       S_AXI_ACLK,
	input  wire                       S_AXI_ARESETN,
	input  wire axi_pkg::axi_wr_req_t wr_req,
	output wire axi_pkg::axi_wr_rsp_t wr_rsp,
	input  wire axi_pkg::axi_rd_req_t rd_req,
	output wire axi_pkg::axi_rd_rsp_t rd_rsp,
	input  wire fir_pkg::sample_t     flt_in,
	input  wire                       in_req,
	output wire                       in_ack,
	output wire fir_pkg::sample_t     flt_out,
	output wire                       out_strobe,
	output wire [7:0]                 leds
);

	fir_pkg::reg_wr_t    reg_wr;
	fir_pkg::word_addr_t rd_addr;
	logic [31:0]         rd_data;
	fir_pkg::coef_wr_t   coef_wr;
	logic                fir_en;
	fir_pkg::tap_idx_t   tap;
	fir_pkg::coef_t      coef;
	logic                last;
	logic                start;
	logic                load;
	logic                finish;

	// bus side
	axi_lite_ctrl u_axi (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.wr_req        (wr_req),
		.wr_rsp        (wr_rsp),
		.rd_req        (rd_req),
		.rd_rsp        (rd_rsp),
		.reg_wr        (reg_wr),
		.rd_addr       (rd_addr),
		.rd_data       (rd_data)
	);

	fir_regs u_regs (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.reg_wr        (reg_wr),
		.rd_addr       (rd_addr),
		.rd_data       (rd_data),
		.coef_wr       (coef_wr),
		.fir_en        (fir_en),
		.leds          (leds)
	);

	// sample side
	fir_seq u_seq (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.in_req        (in_req),
		.in_ack        (in_ack),
		.last          (last),
		.start         (start),
		.load          (load),
		.finish        (finish)
	);

	tap_counter u_cnt (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.start         (start),
		.tap           (tap),
		.last          (last)
	);

	coef_bank u_coef (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.coef_wr       (coef_wr),
		.rd_tap        (tap),
		.coef          (coef)
	);

	fir_mac u_mac (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.flt_in        (flt_in),
		.load          (load),
		.tap           (tap),
		.coef          (coef),
		.finish        (finish),
		.fir_en        (fir_en),
		.flt_out       (flt_out),
		.out_strobe    (out_strobe)
	);

endmodule

`default_nettype wire

// File: src/tap_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "fir_cfg.svh"

module tap_counter (
	input  wire               S_AXI_ACLK,
	input  wire               S_AXI_ARESETN,
	input  wire               start,
	output fir_pkg::tap_idx_t tap,
	output logic              last
);

	logic running;

	assign last = running && (tap == fir_pkg::tap_idx_t'(`FIR_TAPS - 1));

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			tap     <= '0;
			running <= 1'b0;
		end else if (last) begin
			tap     <= '0;   // park at zero between samples
			running <= 1'b0;
		end else if (running) begin
			tap <= tap + 1'b1;
		end else if (start) begin
			running <= 1'b1;   // tap 0 is already on the output
		end
	end

endmodule

`default_nettype wire
